/* Bender.yml */
package:
  name: hid_ps2

sources:
  - include_dirs:
      - source
    files:
      - source/hid_ps2_pkg.sv
      - source/hid_ps2_keymap.sv
      - source/hid_ps2_sequencer.sv
      - source/hid_ps2_translator.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/hid_ps2_checker.sv
      - testbench/tb_hid_ps2.sv

/* source/hid_ps2_cfg.svh */
`ifndef HID_PS2_CFG_SVH
`define HID_PS2_CFG_SVH

// Fixed by the HID usage table
`define HID_USAGE_W 8

// One PS/2 frame payload
`define PS2_BYTE_W 8

// Set-2 prefixes
`define PS2_EXT_PREFIX   8'he0
`define PS2_BREAK_PREFIX 8'hf0

`endif

/* source/hid_ps2_keymap.sv */
`timescale 1ns/100ps
`default_nettype none

module hid_ps2_keymap (
	input  wire                       clk,
	input  wire hid_ps2_pkg::hid_usage_t key,
	output hid_ps2_pkg::ps2_byte_t    map_code,
	output logic                      map_ext
);

	import hid_ps2_pkg::*;

	// Registered lookup, zero code marks an unmapped usage
	always_ff @(posedge clk) begin
		map_ext <= 1'b0;
		case (key)
			HID_A:         map_code <= 8'h1c;
			HID_B:         map_code <= 8'h32;
			HID_C:         map_code <= 8'h21;
			HID_D:         map_code <= 8'h23;
			HID_E:         map_code <= 8'h24;
			HID_F:         map_code <= 8'h2b;
			HID_G:         map_code <= 8'h34;
			HID_H:         map_code <= 8'h33;
			HID_I:         map_code <= 8'h43;
			HID_J:         map_code <= 8'h3b;
			HID_K:         map_code <= 8'h42;
			HID_L:         map_code <= 8'h4b;
			HID_M:         map_code <= 8'h3a;
			HID_N:         map_code <= 8'h31;
			HID_O:         map_code <= 8'h44;
			HID_P:         map_code <= 8'h4d;
			HID_Q:         map_code <= 8'h15;
			HID_R:         map_code <= 8'h2d;
			HID_S:         map_code <= 8'h1b;
			HID_T:         map_code <= 8'h2c;
			HID_U:         map_code <= 8'h3c;
			HID_V:         map_code <= 8'h2a;
			HID_W:         map_code <= 8'h1d;
			HID_X:         map_code <= 8'h22;
			HID_Y:         map_code <= 8'h35;
			HID_Z:         map_code <= 8'h1a;
			HID_1:         map_code <= 8'h16;
			HID_2:         map_code <= 8'h1e;
			HID_3:         map_code <= 8'h26;
			HID_4:         map_code <= 8'h25;
			HID_5:         map_code <= 8'h2e;
			HID_6:         map_code <= 8'h36;
			HID_7:         map_code <= 8'h3d;
			HID_8:         map_code <= 8'h3e;
			HID_9:         map_code <= 8'h46;
			HID_0:         map_code <= 8'h45;
			HID_ENTER:     map_code <= 8'h5a;
			HID_ESC:       map_code <= 8'h76;
			HID_BACKSPACE: map_code <= 8'h66;
			HID_TAB:       map_code <= 8'h0d;
			HID_SPACE:     map_code <= 8'h29;
			HID_F1:        map_code <= 8'h05;
			HID_F2:        map_code <= 8'h06;
			HID_F3:        map_code <= 8'h04;
			HID_F4:        map_code <= 8'h0c;
			HID_F5:        map_code <= 8'h03;
			HID_F6:        map_code <= 8'h0b;
			HID_F7:        map_code <= 8'h83; // Only code above 7f
			HID_F8:        map_code <= 8'h0a;
			HID_F9:        map_code <= 8'h01;
			HID_F10:       map_code <= 8'h09;
			HID_F11:       map_code <= 8'h78;
			HID_F12:       map_code <= 8'h07;
			HID_INSERT: begin
				map_code <= 8'h70;
				map_ext  <= 1'b1;
			end
			HID_HOME: begin
				map_code <= 8'h6c;
				map_ext  <= 1'b1;
			end
			HID_PAGEUP: begin
				map_code <= 8'h7d;
				map_ext  <= 1'b1;
			end
			HID_DELETE: begin
				map_code <= 8'h71;
				map_ext  <= 1'b1;
			end
			HID_END: begin
				map_code <= 8'h69;
				map_ext  <= 1'b1;
			end
			HID_PAGEDOWN: begin
				map_code <= 8'h7a;
				map_ext  <= 1'b1;
			end
			HID_RIGHT: begin
				map_code <= 8'h74;
				map_ext  <= 1'b1;
			end
			HID_LEFT: begin
				map_code <= 8'h6b;
				map_ext  <= 1'b1;
			end
			HID_DOWN: begin
				map_code <= 8'h72;
				map_ext  <= 1'b1;
			end
			HID_UP: begin
				map_code <= 8'h75;
				map_ext  <= 1'b1;
			end
			// Right Ctrl and Alt reuse the left codes behind E0
			HID_LEFTCTRL:   map_code <= 8'h14;
			HID_LEFTSHIFT:  map_code <= 8'h12;
			HID_LEFTALT:    map_code <= 8'h11;
			HID_RIGHTSHIFT: map_code <= 8'h59;
			HID_LEFTMETA: begin
				map_code <= 8'h1f;
				map_ext  <= 1'b1;
			end
			HID_RIGHTCTRL: begin
				map_code <= 8'h14;
				map_ext  <= 1'b1;
			end
			HID_RIGHTALT: begin
				map_code <= 8'h11;
				map_ext  <= 1'b1;
			end
			HID_RIGHTMETA: begin
				map_code <= 8'h27;
				map_ext  <= 1'b1;
			end
			default:       map_code <= '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/hid_ps2_pkg.sv */
`default_nettype none

`include "hid_ps2_cfg.svh"

package hid_ps2_pkg;

	typedef logic [`PS2_BYTE_W-1:0] ps2_byte_t;

	// Usage codes that have a set-2 translation
	typedef enum logic [`HID_USAGE_W-1:0] {
		HID_NONE = 8'h00,
		HID_A = 8'h04, HID_B = 8'h05, HID_C = 8'h06, HID_D = 8'h07,
		HID_E = 8'h08, HID_F = 8'h09, HID_G = 8'h0a, HID_H = 8'h0b,
		HID_I = 8'h0c, HID_J = 8'h0d, HID_K = 8'h0e, HID_L = 8'h0f,
		HID_M = 8'h10, HID_N = 8'h11, HID_O = 8'h12, HID_P = 8'h13,
		HID_Q = 8'h14, HID_R = 8'h15, HID_S = 8'h16, HID_T = 8'h17,
		HID_U = 8'h18, HID_V = 8'h19, HID_W = 8'h1a, HID_X = 8'h1b,
		HID_Y = 8'h1c, HID_Z = 8'h1d,
		// Top row digits, zero comes last in HID order
		HID_1 = 8'h1e, HID_2 = 8'h1f, HID_3 = 8'h20, HID_4 = 8'h21,
		HID_5 = 8'h22, HID_6 = 8'h23, HID_7 = 8'h24, HID_8 = 8'h25,
		HID_9 = 8'h26, HID_0 = 8'h27,
		HID_ENTER     = 8'h28,
		HID_ESC       = 8'h29,
		HID_BACKSPACE = 8'h2a,
		HID_TAB       = 8'h2b,
		HID_SPACE     = 8'h2c,
		HID_F1  = 8'h3a, HID_F2  = 8'h3b, HID_F3  = 8'h3c, HID_F4  = 8'h3d,
		HID_F5  = 8'h3e, HID_F6  = 8'h3f, HID_F7  = 8'h40, HID_F8  = 8'h41,
		HID_F9  = 8'h42, HID_F10 = 8'h43, HID_F11 = 8'h44, HID_F12 = 8'h45,
		// Navigation block, all extended in set 2
		HID_INSERT   = 8'h49,
		HID_HOME     = 8'h4a,
		HID_PAGEUP   = 8'h4b,
		HID_DELETE   = 8'h4c,
		HID_END      = 8'h4d,
		HID_PAGEDOWN = 8'h4e,
		HID_RIGHT    = 8'h4f,
		HID_LEFT     = 8'h50,
		HID_DOWN     = 8'h51,
		HID_UP       = 8'h52,
		// Modifiers
		HID_LEFTCTRL   = 8'he0,
		HID_LEFTSHIFT  = 8'he1,
		HID_LEFTALT    = 8'he2,
		HID_LEFTMETA   = 8'he3,
		HID_RIGHTCTRL  = 8'he4,
		HID_RIGHTSHIFT = 8'he5,
		HID_RIGHTALT   = 8'he6,
		HID_RIGHTMETA  = 8'he7
	} hid_usage_t;

	typedef enum logic [2:0] {
		SEQ_IDLE   = 3'd0,
		SEQ_LOOKUP = 3'd1, // Key map latency
		SEQ_EXT    = 3'd2,
		SEQ_BRK    = 3'd3,
		SEQ_CODE   = 3'd4,
		SEQ_WAIT   = 3'd5  // Serializer busy
	} seq_state_t;

endpackage

`default_nettype wire

/* source/hid_ps2_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hid_ps2_cfg.svh"

module hid_ps2_sequencer (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          rq,
	input  wire hid_ps2_pkg::hid_usage_t keycheck,
	input  wire                          released,
	input  wire                          ser_rdy,
	output logic                         idle,
	output logic                         ser_send,
	output hid_ps2_pkg::ps2_byte_t       ps2_code,
	output hid_ps2_pkg::hid_usage_t      key,
	input  wire hid_ps2_pkg::ps2_byte_t  map_code,
	input  wire                          map_ext
);

	import hid_ps2_pkg::*;

	seq_state_t state;
	seq_state_t ret_state; // Where to go once the serializer is busy
	logic       rel;
	logic       accept;

	assign idle   = (state == SEQ_IDLE);
	assign accept = rq && idle;

	// Request payload, held for the whole sequence
	always_ff @(posedge clk) begin
		if (accept) begin
			key <= keycheck;
			rel <= released;
		end
	end

	always_ff @(posedge clk) begin
		ser_send <= 1'b0; // Single cycle pulse
		if (rst) begin
			state     <= SEQ_IDLE;
			ret_state <= SEQ_IDLE;
			ps2_code  <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (rq)
						state <= SEQ_LOOKUP;
				end
				SEQ_LOOKUP: state <= SEQ_EXT; // map_code valid from next cycle
				SEQ_EXT: begin
					if (map_code == '0) begin
						state <= SEQ_IDLE; // Unmapped, nothing to send
					end else if (!map_ext) begin
						state <= rel ? SEQ_BRK : SEQ_CODE;
					end else if (ser_rdy) begin
						ps2_code  <= `PS2_EXT_PREFIX;
						ser_send  <= 1'b1;
						ret_state <= rel ? SEQ_BRK : SEQ_CODE;
						state     <= SEQ_WAIT;
					end
				end
				SEQ_BRK: begin
					if (ser_rdy) begin
						ps2_code  <= `PS2_BREAK_PREFIX;
						ser_send  <= 1'b1;
						ret_state <= SEQ_CODE;
						state     <= SEQ_WAIT;
					end
				end
				SEQ_CODE: begin
					if (ser_rdy) begin
						ps2_code  <= map_code;
						ser_send  <= 1'b1;
						ret_state <= SEQ_IDLE;
						state     <= SEQ_WAIT;
					end
				end
				SEQ_WAIT: begin
					// Serializer drops ready once it has taken the byte
					if (!ser_rdy)
						state <= ret_state;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/hid_ps2_translator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hid_ps2_cfg.svh"

module hid_ps2_translator (
	input  wire                         clk,
	input  wire                         rst,
	input  wire [`HID_USAGE_W-1:0]      keycheck,
	input  wire                         released,
	input  wire                         rq,
	input  wire                         ser_rdy,
	output logic                        idle,
	output logic                        ser_send,
	output hid_ps2_pkg::ps2_byte_t      ps2_code
);

	import hid_ps2_pkg::*;

	hid_usage_t keycheck_usage; // Raw usage, may be outside the kept set
	hid_usage_t key;
	ps2_byte_t  map_code;
	logic       map_ext;

	assign keycheck_usage = hid_usage_t'(keycheck);

	hid_ps2_keymap u_keymap (
		.clk      (clk),
		.key      (key),
		.map_code (map_code),
		.map_ext  (map_ext)
	);

	hid_ps2_sequencer u_sequencer (
		.clk      (clk),
		.rst      (rst),
		.rq       (rq),
		.keycheck (keycheck_usage),
		.released (released),
		.ser_rdy  (ser_rdy),
		.idle     (idle),
		.ser_send (ser_send),
		.ps2_code (ps2_code),
		.key      (key),
		.map_code (map_code),
		.map_ext  (map_ext)
	);

endmodule

`default_nettype wire

/* testbench/hid_ps2_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hid_ps2_cfg.svh"

module hid_ps2_checker (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         rq,
	input  wire [`HID_USAGE_W-1:0]      keycheck,
	input  wire                         released,
	input  wire                         ser_rdy,
	input  wire                         idle,
	input  wire                         ser_send,
	input  wire hid_ps2_pkg::ps2_byte_t ps2_code,
	output int                          error_count,
	output int                          byte_count,
	output int                          request_count
);

	import hid_ps2_pkg::*;

	// Set-2 codes in HID order with the first key in the top byte
	localparam logic [41*8-1:0] MAIN_CODES = { // A to Z, 1 to 0, Enter to Space
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a,
		8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45,
		8'h5a, 8'h76, 8'h66, 8'h0d, 8'h29
	};
	localparam logic [12*8-1:0] FKEY_CODES = {
		8'h05, 8'h06, 8'h04, 8'h0c, 8'h03, 8'h0b,
		8'h83, 8'h0a, 8'h01, 8'h09, 8'h78, 8'h07
	};
	localparam logic [10*8-1:0] NAV_CODES = { // Insert to Up arrow
		8'h70, 8'h6c, 8'h7d, 8'h71, 8'h69, 8'h7a, 8'h74, 8'h6b, 8'h72, 8'h75
	};
	localparam logic [8*8-1:0] MOD_CODES = {
		8'h14, 8'h12, 8'h11, 8'h1f, 8'h14, 8'h59, 8'h11, 8'h27
	};
	localparam logic [7:0] MOD_EXT = 8'b0001_1011; // Left Ctrl in the top bit

	ps2_byte_t   exp_q[$];
	ps2_byte_t   exp_byte;
	logic [31:0] ref_seq;
	logic [7:0]  cur_usage;
	logic        busy;
	logic        mapped;
	logic        first_check;
	logic        prev_rdy;
	int          busy_cycles;
	int          i;

	// Count in [31:24] and bytes in send order from [23:16] down
	function automatic logic [31:0] expected_bytes(input logic [7:0] usage, input logic rel);
		ps2_byte_t   code;
		logic        ext;
		logic [23:0] seq;
		int          n;
		code = '0;
		ext  = 1'b0;
		seq  = '0;
		n    = 0;
		if (usage >= HID_A && usage <= HID_SPACE)
			code = MAIN_CODES[(HID_SPACE - usage)*8 +: 8];
		else if (usage >= HID_F1 && usage <= HID_F12)
			code = FKEY_CODES[(HID_F12 - usage)*8 +: 8];
		else if (usage >= HID_INSERT && usage <= HID_UP) begin
			code = NAV_CODES[(HID_UP - usage)*8 +: 8];
			ext  = 1'b1;
		end else if (usage >= HID_LEFTCTRL && usage <= HID_RIGHTMETA) begin
			code = MOD_CODES[(HID_RIGHTMETA - usage)*8 +: 8];
			ext  = MOD_EXT[HID_RIGHTMETA - usage];
		end
		if (code != '0) begin
			if (ext) begin
				seq[23-8*n -: 8] = `PS2_EXT_PREFIX;
				n++;
			end
			if (rel) begin
				seq[23-8*n -: 8] = `PS2_BREAK_PREFIX;
				n++;
			end
			seq[23-8*n -: 8] = code;
			n++;
		end
		return {8'(n), seq};
	endfunction

	// Everything is stable at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			exp_q.delete();
			busy          = 1'b0;
			first_check   = 1'b1;
			error_count   = 0;
			byte_count    = 0;
			request_count = 0;
		end else begin
			if (first_check && ps2_code !== '0) begin
				error_count++;
				$display("FAIL ps2_code after reset: expected 00, got %h", ps2_code);
			end
			first_check = 1'b0;
			if (!busy && idle !== 1'b1) begin
				error_count++;
				$display("FAIL idle: expected 1, got %h with no accepted request", idle);
			end
			if (ser_send) begin
				byte_count++;
				if (!prev_rdy) begin
					error_count++;
					$display("Byte sent while the serializer was not ready");
				end
				if (exp_q.size() == 0) begin
					error_count++;
					$display("Extra byte %h sent beyond the expected sequence", ps2_code);
				end else begin
					exp_byte = exp_q.pop_front();
					if (ps2_code !== exp_byte) begin
						error_count++;
						$display("FAIL ps2_code: expected %h, got %h (usage %h)",
							exp_byte, ps2_code, cur_usage);
					end
				end
			end
			if (busy && idle) begin // End of a sequence
				if (exp_q.size() != 0) begin
					error_count++;
					$display("Sequence for usage %h ended with %0d bytes not sent",
						cur_usage, exp_q.size());
				end
				if (!mapped && busy_cycles != 2) begin
					error_count++;
					$display("Unmapped usage %h kept idle low for %0d cycles instead of 2",
						cur_usage, busy_cycles);
				end
				exp_q.delete();
				busy = 1'b0;
			end
			if (busy)
				busy_cycles++;
			// Accepted at the coming rising edge
			if (rq && idle) begin
				ref_seq   = expected_bytes(keycheck, released);
				cur_usage = keycheck;
				mapped    = (ref_seq[31:24] != 0);
				for (i = 0; i < ref_seq[31:24]; i++)
					exp_q.push_back(ref_seq[23-8*i -: 8]);
				busy        = 1'b1;
				busy_cycles = 0;
				request_count++;
			end
		end
		prev_rdy = ser_rdy;
	end

endmodule

`default_nettype wire

/* testbench/tb_hid_ps2.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hid_ps2_cfg.svh"

module tb_hid_ps2;

	import hid_ps2_pkg::*;

	localparam int NUM_REQ     = 200;
	localparam int CYCLE_LIMIT = NUM_REQ * 60;

	logic                    clk;
	logic                    rst;
	logic                    rq;
	logic [`HID_USAGE_W-1:0] keycheck;
	logic                    released;
	logic                    ser_rdy = 1'b1;
	logic                    idle;
	logic                    ser_send;
	ps2_byte_t               ps2_code;

	integer seed = 32'hdb57832f;
	int     low_cnt = 0; // Serializer shift cycles left
	int     cycles = 0;
	int     stim_errors = 0;
	int     error_count;
	int     byte_count;
	int     request_count;

	logic [`HID_USAGE_W-1:0] usage_list [0:NUM_REQ-1];
	logic                    rel_list [0:NUM_REQ-1];

	hid_ps2_translator u_dut (
		.clk      (clk),
		.rst      (rst),
		.keycheck (keycheck),
		.released (released),
		.rq       (rq),
		.ser_rdy  (ser_rdy),
		.idle     (idle),
		.ser_send (ser_send),
		.ps2_code (ps2_code)
	);

	hid_ps2_checker u_chk (
		.clk           (clk),
		.rst           (rst),
		.rq            (rq),
		.keycheck      (keycheck),
		.released      (released),
		.ser_rdy       (ser_rdy),
		.idle          (idle),
		.ser_send      (ser_send),
		.ps2_code      (ps2_code),
		.error_count   (error_count),
		.byte_count    (byte_count),
		.request_count (request_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Serializer model, busy for 1 to 8 cycles after each byte
	always @(posedge clk) begin
		if (rst) begin
			ser_rdy <= 1'b1;
			low_cnt <= 0;
		end else if (ser_send) begin
			ser_rdy <= 1'b0;
			low_cnt <= 1 + ($unsigned($random(seed)) % 8);
		end else if (low_cnt > 1) begin
			low_cnt <= low_cnt - 1;
		end else if (low_cnt == 1) begin
			ser_rdy <= 1'b1;
			low_cnt <= 0;
		end
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic is_kept(input logic [7:0] u);
		return (u >= 8'h04 && u <= 8'h2c) || (u >= 8'h3a && u <= 8'h45) ||
			(u >= 8'h49 && u <= 8'h52) || (u >= 8'he0 && u <= 8'he7);
	endfunction

	// Every kept key pressed and released, unmapped codes fill the rest
	task automatic build_list();
		int         n;
		int         j;
		logic [7:0] u;
		logic       r;
		n = 0;
		for (int v = 0; v < 256; v++) begin
			if (is_kept(8'(v))) begin
				usage_list[n]   = 8'(v);
				rel_list[n]     = 1'b0;
				usage_list[n+1] = 8'(v);
				rel_list[n+1]   = 1'b1;
				n += 2;
			end
		end
		while (n < NUM_REQ) begin
			do
				u = 8'($random(seed));
			while (is_kept(u));
			usage_list[n] = u;
			rel_list[n]   = 1'(rand_below(2));
			n++;
		end
		for (int k = NUM_REQ - 1; k > 0; k--) begin
			j             = rand_below(k + 1);
			u             = usage_list[k];
			r             = rel_list[k];
			usage_list[k] = usage_list[j];
			rel_list[k]   = rel_list[j];
			usage_list[j] = u;
			rel_list[j]   = r;
		end
	endtask

	task automatic wait_idle();
		do
			@(negedge clk);
		while (!idle);
	endtask

	task automatic issue_request(input logic [7:0] u, input logic rel);
		int delay;
		delay = rand_below(4);
		wait_idle();
		repeat (delay) @(posedge clk);
		@(posedge clk);
		rq       <= 1'b1;
		keycheck <= u;
		released <= rel;
		@(posedge clk);
		rq <= 1'b0;
		// A second strobe while busy, lands during the first byte's wait
		if (is_kept(u) && rand_below(2) == 1) begin
			do
				@(negedge clk);
			while (!ser_send);
			@(posedge clk);
			rq       <= 1'b1;
			keycheck <= 8'($random(seed));
			released <= 1'(rand_below(2));
			@(posedge clk);
			rq <= 1'b0;
		end
	endtask

	task automatic report_counts();
		$display("Requests %0d, bytes %0d, errors %0d",
			request_count, byte_count, error_count + stim_errors);
	endtask

	initial begin
		rst      = 1'b1;
		rq       = 1'b0;
		keycheck = '0;
		released = 1'b0;
		build_list();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n < NUM_REQ; n++)
			issue_request(usage_list[n], rel_list[n]);
		wait_idle();
		repeat (5) @(posedge clk);
		if (request_count != NUM_REQ) begin
			stim_errors++;
			$display("Only %0d of %0d requests were accepted", request_count, NUM_REQ);
		end
		report_counts();
		if (error_count + stim_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		report_counts();
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/hid_ps2_pkg.sv
source/hid_ps2_keymap.sv
source/hid_ps2_sequencer.sv
source/hid_ps2_translator.sv
testbench/hid_ps2_checker.sv
testbench/tb_hid_ps2.sv
